//--- source/ccx_pkg.sv
package ccx_pkg;

   // Default sizes for the top level parameters
   localparam int NUM_CORES_DEF = 4;   // Requesting cores
   localparam int NUM_DEST_DEF  = 2;   // Cache banks
   localparam int DATA_W_DEF    = 64;  // Packet payload bits

   // Max ungranted packets per core and bank
   localparam int QUEUE_DEPTH = 2;

   // Index width for n items with a minimum of one bit
   function automatic int idx_w(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

   // Per-bank arbiter state
   typedef enum logic {
      ARB_IDLE     = 1'b0,  // Free round-robin pick
      ARB_ATOM_2ND = 1'b1   // Locked on one core for the second half of a pair
   } arb_state_e;

endpackage

//--- source/pcx_ingress.sv
`timescale 1ns/10ps

// Request staging for the processor-to-cache path
// A core raises its bank request in pq and drives the packet in pa, so the
// request is held one cycle here and meets its data on the way into the queue
module pcx_ingress #(
   parameter int num_cores = ccx_pkg::NUM_CORES_DEF,
   parameter int num_dest  = ccx_pkg::NUM_DEST_DEF,
   parameter int data_w    = ccx_pkg::DATA_W_DEF
) (
   input  logic                                rclk,
   input  logic                                rst_n,
   input  logic [num_cores-1:0][num_dest-1:0]  spc_req_pq,   // One-hot bank per core
   input  logic [num_cores-1:0]                spc_atom_pq,  // First half of a pair
   input  logic [num_cores-1:0][data_w-1:0]    spc_data_pa,  // One cycle after request
   output logic [num_cores-1:0]                wr_en,        // Queue write per core
   output logic [num_cores-1:0][ccx_pkg::idx_w(num_dest)-1:0] wr_dest,
   output logic [num_cores-1:0][data_w-1:0]    wr_data,
   output logic [num_cores-1:0]                wr_atom
);

   localparam int dst_w = ccx_pkg::idx_w(num_dest);

   logic [num_cores-1:0]            req_vld;     // Any bank bit set
   logic [num_cores-1:0][dst_w-1:0] req_dest;    // Encoded bank
   logic [num_cores-1:0]            stg_vld_q;   // Request waiting for its data
   logic [num_cores-1:0]            stg_atom_q;
   logic [num_cores-1:0][dst_w-1:0] stg_dest_q;

   // One-hot to index
   // Lowest set bit wins if a core ever drives more than one
   always_comb begin
      for (int c = 0; c < num_cores; c++) begin
         req_vld[c]  = |spc_req_pq[c];
         req_dest[c] = '0;
         for (int d = num_dest - 1; d >= 0; d--) begin
            if (spc_req_pq[c][d]) begin
               req_dest[c] = dst_w'(d);
            end
         end
      end
   end

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         stg_vld_q  <= '0;
         stg_atom_q <= '0;
      end else begin
         stg_vld_q  <= req_vld;
         stg_atom_q <= req_vld & spc_atom_pq;  // Flag means nothing without a request
      end
   end

   // Encoded bank held with the staged request
   always_ff @(posedge rclk) begin
      for (int c = 0; c < num_cores; c++) begin
         if (req_vld[c]) begin
            stg_dest_q[c] <= req_dest[c];
         end
      end
   end

   // In the pa cycle the staged header and the arriving data form the packet
   assign wr_en   = stg_vld_q;
   assign wr_dest = stg_dest_q;   // Picks the queue within this core's row
   assign wr_atom = stg_atom_q;
   assign wr_data = spc_data_pa;  // Captured by the queue at the same edge

endmodule

//--- source/pcx_src_queue.sv
`timescale 1ns/10ps

// One small FIFO per core and bank pair
// Holds the packets a core has sent but that the bank arbiter has not yet taken
module pcx_src_queue #(
   parameter int num_cores = ccx_pkg::NUM_CORES_DEF,
   parameter int num_dest  = ccx_pkg::NUM_DEST_DEF,
   parameter int data_w    = ccx_pkg::DATA_W_DEF
) (
   input  logic                                            rclk,
   input  logic                                            rst_n,
   input  logic [num_cores-1:0]                            wr_en,
   input  logic [num_cores-1:0][ccx_pkg::idx_w(num_dest)-1:0] wr_dest,
   input  logic [num_cores-1:0][data_w-1:0]                wr_data,
   input  logic [num_cores-1:0]                            wr_atom,
   input  logic [num_cores-1:0][num_dest-1:0]              pop,        // From bank arbiters
   output logic [num_cores-1:0][num_dest-1:0]              not_empty,
   output logic [num_cores-1:0][num_dest-1:0][data_w-1:0]  head_data,
   output logic [num_cores-1:0][num_dest-1:0]              head_atom
);

   localparam int depth = ccx_pkg::QUEUE_DEPTH;
   localparam int dst_w = ccx_pkg::idx_w(num_dest);
   localparam int ptr_w = ccx_pkg::idx_w(depth);
   localparam int cnt_w = $clog2(depth + 1);

   // Pointer step with wrap at the last entry
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
   endfunction

   for (genvar c = 0; c < num_cores; c++) begin : g_core
      for (genvar d = 0; d < num_dest; d++) begin : g_dest
         logic [data_w:0]  mem [depth];  // {atom, data}
         logic [ptr_w-1:0] wr_ptr_q;
         logic [ptr_w-1:0] rd_ptr_q;
         logic [cnt_w-1:0] cnt_q;
         logic             push;

         assign push = wr_en[c] && (wr_dest[c] == dst_w'(d));

         always_ff @(posedge rclk or negedge rst_n) begin
            if (!rst_n) begin
               wr_ptr_q <= '0;
               rd_ptr_q <= '0;
               cnt_q    <= '0;
            end else begin
               if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
               if (pop[c][d]) rd_ptr_q <= ptr_inc(rd_ptr_q);
               // Push and pop together leave the count alone
               case ({push, pop[c][d]})
                  2'b10:   cnt_q <= cnt_q + 1'b1;
                  2'b01:   cnt_q <= cnt_q - 1'b1;
                  default: cnt_q <= cnt_q;
               endcase
            end
         end

         always_ff @(posedge rclk) begin
            if (push) mem[wr_ptr_q] <= {wr_atom[c], wr_data[c]};
         end

         assign not_empty[c][d] = (cnt_q != '0);  // Seen the cycle after the write
         assign {head_atom[c][d], head_data[c][d]} = mem[rd_ptr_q];
      end
   end

endmodule

//--- source/pcx_dest_arb.sv
`timescale 1ns/10ps

// Per-bank round-robin arbiter and output stage
// Picks one core per bank each cycle, pops its head, registers the packet
// toward the bank and the grant back toward the core
module pcx_dest_arb #(
   parameter int num_cores = ccx_pkg::NUM_CORES_DEF,
   parameter int num_dest  = ccx_pkg::NUM_DEST_DEF,
   parameter int data_w    = ccx_pkg::DATA_W_DEF
) (
   input  logic                                            rclk,
   input  logic                                            rst_n,
   input  logic [num_dest-1:0]                             dest_stall_pq,  // Level per bank
   input  logic [num_cores-1:0][num_dest-1:0]              not_empty,
   input  logic [num_cores-1:0][num_dest-1:0][data_w-1:0]  head_data,
   input  logic [num_cores-1:0][num_dest-1:0]              head_atom,
   output logic [num_cores-1:0][num_dest-1:0]              pop,
   output logic [num_cores-1:0][num_dest-1:0]              spc_grant_px,
   output logic [num_dest-1:0]                             dest_data_rdy_px,
   output logic [num_dest-1:0][data_w-1:0]                 dest_data_px,
   output logic [num_dest-1:0]                             dest_atom_px,
   output logic [num_dest-1:0][ccx_pkg::idx_w(num_cores)-1:0] dest_src_px
);

   localparam int src_w = ccx_pkg::idx_w(num_cores);

   ccx_pkg::arb_state_e             state_q [num_dest];  // Atomic lock per bank
   logic [num_dest-1:0][src_w-1:0]  rr_ptr_q;    // Highest priority core
   logic [num_dest-1:0][src_w-1:0]  lock_src_q;  // Core owning the pair
   logic [num_dest-1:0]             sel_vld;     // Bank delivers at next edge
   logic [num_dest-1:0][src_w-1:0]  sel_src;

   // Core after s with wrap at num_cores
   function automatic logic [src_w-1:0] rr_next(input logic [src_w-1:0] s);
      return (s == src_w'(num_cores - 1)) ? '0 : s + 1'b1;
   endfunction

   always_comb begin
      int idx;
      idx = 0;
      pop = '0;
      for (int d = 0; d < num_dest; d++) begin
         sel_vld[d] = 1'b0;
         sel_src[d] = '0;
         if (state_q[d] == ccx_pkg::ARB_ATOM_2ND) begin
            // Second half of a pair ignores stall
            sel_vld[d] = not_empty[lock_src_q[d]][d];
            sel_src[d] = lock_src_q[d];
         end else if (!dest_stall_pq[d]) begin
            // Scan from the far end so the core nearest the pointer wins
            for (int i = num_cores - 1; i >= 0; i--) begin
               idx = int'(rr_ptr_q[d]) + i;
               if (idx >= num_cores) idx = idx - num_cores;
               if (not_empty[idx][d]) begin
                  sel_vld[d] = 1'b1;
                  sel_src[d] = src_w'(idx);
               end
            end
         end
         if (sel_vld[d]) pop[sel_src[d]][d] = 1'b1;  // Head leaves at the next edge
      end
   end

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int d = 0; d < num_dest; d++) begin
            state_q[d] <= ccx_pkg::ARB_IDLE;
         end
         rr_ptr_q         <= '0;  // Core 0 first
         lock_src_q       <= '0;
         spc_grant_px     <= '0;
         dest_data_rdy_px <= '0;
         dest_atom_px     <= '0;
      end else begin
         spc_grant_px     <= pop;      // One grant per delivered packet
         dest_data_rdy_px <= sel_vld;
         for (int d = 0; d < num_dest; d++) begin
            dest_atom_px[d] <= sel_vld[d] & head_atom[sel_src[d]][d];
            if (sel_vld[d]) rr_ptr_q[d] <= rr_next(sel_src[d]);
            if (state_q[d] == ccx_pkg::ARB_ATOM_2ND) begin
               state_q[d] <= ccx_pkg::ARB_IDLE;  // Lock holds for one cycle only
            end else if (sel_vld[d] && head_atom[sel_src[d]][d]) begin
               // First half goes out so the bank stays with the same core
               state_q[d]    <= ccx_pkg::ARB_ATOM_2ND;
               lock_src_q[d] <= sel_src[d];
            end
         end
      end
   end

   // Packet and source of the delivered head
   always_ff @(posedge rclk) begin
      for (int d = 0; d < num_dest; d++) begin
         if (sel_vld[d]) begin
            dest_data_px[d] <= head_data[sel_src[d]][d];
            dest_src_px[d]  <= sel_src[d];
         end
      end
   end

endmodule

//--- source/pcx_xbar.sv
`timescale 1ns/10ps

// Processor-to-cache crossbar
// Cores -> staging -> per-pair queues -> per-bank arbiters -> banks
module pcx_xbar #(
   parameter int num_cores = ccx_pkg::NUM_CORES_DEF,
   parameter int num_dest  = ccx_pkg::NUM_DEST_DEF,
   parameter int data_w    = ccx_pkg::DATA_W_DEF
) (
   input  logic                                rclk,
   input  logic                                rst_n,
   input  logic [num_cores-1:0][num_dest-1:0]  spc_req_pq,
   input  logic [num_cores-1:0]                spc_atom_pq,
   input  logic [num_cores-1:0][data_w-1:0]    spc_data_pa,
   input  logic [num_dest-1:0]                 dest_stall_pq,
   output logic [num_cores-1:0][num_dest-1:0]  spc_grant_px,      // Per core, per bank
   output logic [num_dest-1:0]                 dest_data_rdy_px,
   output logic [num_dest-1:0][data_w-1:0]     dest_data_px,
   output logic [num_dest-1:0]                 dest_atom_px,
   output logic [num_dest-1:0][ccx_pkg::idx_w(num_cores)-1:0] dest_src_px
);

   localparam int dst_w = ccx_pkg::idx_w(num_dest);

   // Staging to queues
   logic [num_cores-1:0]             wr_en;
   logic [num_cores-1:0][dst_w-1:0]  wr_dest;
   logic [num_cores-1:0][data_w-1:0] wr_data;
   logic [num_cores-1:0]             wr_atom;

   // Queues to arbiters and back
   logic [num_cores-1:0][num_dest-1:0]             not_empty;
   logic [num_cores-1:0][num_dest-1:0][data_w-1:0] head_data;
   logic [num_cores-1:0][num_dest-1:0]             head_atom;
   logic [num_cores-1:0][num_dest-1:0]             pop;

   pcx_ingress #(.num_cores(num_cores), .num_dest(num_dest), .data_w(data_w))
   pcx_ingress_i (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .spc_req_pq  (spc_req_pq),
      .spc_atom_pq (spc_atom_pq),
      .spc_data_pa (spc_data_pa),
      .wr_en       (wr_en),
      .wr_dest     (wr_dest),
      .wr_data     (wr_data),
      .wr_atom     (wr_atom)
   );

   pcx_src_queue #(.num_cores(num_cores), .num_dest(num_dest), .data_w(data_w))
   pcx_src_queue_i (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_dest   (wr_dest),
      .wr_data   (wr_data),
      .wr_atom   (wr_atom),
      .pop       (pop),
      .not_empty (not_empty),
      .head_data (head_data),
      .head_atom (head_atom)
   );

   pcx_dest_arb #(.num_cores(num_cores), .num_dest(num_dest), .data_w(data_w))
   pcx_dest_arb_i (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .dest_stall_pq    (dest_stall_pq),
      .not_empty        (not_empty),
      .head_data        (head_data),
      .head_atom        (head_atom),
      .pop              (pop),
      .spc_grant_px     (spc_grant_px),
      .dest_data_rdy_px (dest_data_rdy_px),
      .dest_data_px     (dest_data_px),
      .dest_atom_px     (dest_atom_px),
      .dest_src_px      (dest_src_px)
   );

endmodule

//--- dv/pcx_xbar_props.sv
`timescale 1ns/10ps

// Arbiter properties, bound into every bank arbiter
module pcx_dest_arb_props #(
   parameter int num_cores = ccx_pkg::NUM_CORES_DEF,
   parameter int num_dest  = ccx_pkg::NUM_DEST_DEF
) (
   input logic                               rclk,
   input logic                               rst_n,
   input logic [num_dest-1:0]                dest_stall_pq,
   input logic [num_cores-1:0][num_dest-1:0] spc_grant_px,
   input logic [num_dest-1:0]                dest_data_rdy_px,
   input ccx_pkg::arb_state_e                state_q [num_dest]
);

   // Quiet while reset is held
   a_reset_quiet: assert property (@(posedge rclk)
      !rst_n |-> (dest_data_rdy_px == '0) && (spc_grant_px == '0))
      else $error("arbiter outputs active during reset");

   for (genvar d = 0; d < num_dest; d++) begin : g_dest
      // Stall blocks selection unless the bank is locked on a pair
      a_stall_blocks: assert property (@(posedge rclk) disable iff (!rst_n)
         dest_stall_pq[d] && (state_q[d] == ccx_pkg::ARB_IDLE) |=> !dest_data_rdy_px[d])
         else $error("bank %0d delivered after a stalled cycle", d);

      // Lock cycle delivers the second half and then frees the bank
      a_lock_one_cycle: assert property (@(posedge rclk) disable iff (!rst_n)
         (state_q[d] == ccx_pkg::ARB_ATOM_2ND) |=>
            (state_q[d] == ccx_pkg::ARB_IDLE) && dest_data_rdy_px[d])
         else $error("bank %0d did not finish the atomic pair in one lock cycle", d);
   end

endmodule

bind pcx_dest_arb pcx_dest_arb_props #(.num_cores(num_cores), .num_dest(num_dest)) props_i (
   .rclk             (rclk),
   .rst_n            (rst_n),
   .dest_stall_pq    (dest_stall_pq),
   .spc_grant_px     (spc_grant_px),
   .dest_data_rdy_px (dest_data_rdy_px),
   .state_q          (state_q)
);

//--- dv/pcx_xbar_tb.sv
`timescale 1ns/10ps

module pcx_xbar_tb;

   localparam int nc          = ccx_pkg::NUM_CORES_DEF;
   localparam int nd          = ccx_pkg::NUM_DEST_DEF;
   localparam int dw          = ccx_pkg::DATA_W_DEF;
   localparam int depth       = ccx_pkg::QUEUE_DEPTH;
   localparam int rand_cycles = 400;  // Length of the mixed traffic phase

   logic                                  rclk;
   logic                                  rst_n;
   logic [nc-1:0][nd-1:0]                 spc_req_pq;
   logic [nc-1:0]                         spc_atom_pq;
   logic [nc-1:0][dw-1:0]                 spc_data_pa;
   logic [nd-1:0]                         dest_stall_pq;
   logic [nc-1:0][nd-1:0]                 spc_grant_px;
   logic [nd-1:0]                         dest_data_rdy_px;
   logic [nd-1:0][dw-1:0]                 dest_data_px;
   logic [nd-1:0]                         dest_atom_px;
   logic [nd-1:0][ccx_pkg::idx_w(nc)-1:0] dest_src_px;

   logic [dw:0]   exp_q [nc*nd][$];  // Expected {atom, data} per core and bank pair
   int            credit [nc*nd];    // Sent, not yet granted
   int            seq_no [nc*nd];
   int            sent_cnt [nc];
   int            grant_cnt [nc];
   int            sent_total = 0;
   int            err_cnt = 0;
   int            cyc = 0;           // Rising edges so far
   int            log_src [$];       // Deliveries in arrival order
   int            log_cyc [$];
   logic          log_atom [$];
   int            req_dest [nc];     // Request for the next falling edge, -1 for none
   logic          req_atom [nc];
   logic [dw-1:0] pend_data [nc];    // Owed one cycle after its request
   int            second_dest [nc];  // Bank still owed the second half of a pair
   logic [31:0]   rng_state;

   pcx_xbar pcx_xbar_i (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .spc_req_pq       (spc_req_pq),
      .spc_atom_pq      (spc_atom_pq),
      .spc_data_pa      (spc_data_pa),
      .dest_stall_pq    (dest_stall_pq),
      .spc_grant_px     (spc_grant_px),
      .dest_data_rdy_px (dest_data_rdy_px),
      .dest_data_px     (dest_data_px),
      .dest_atom_px     (dest_atom_px),
      .dest_src_px      (dest_src_px)
   );

   initial begin
      rclk = 1'b1;  // First edge falls
      forever #5 rclk = ~rclk;
   end

   // Payload of a packet from core, bank and sequence number plus a scrambled word
   function automatic logic [dw-1:0] ref_data(input int c, input int d, input int seq);
      logic [31:0] mix;
      mix = (32'(seq) * 32'h9e37_79b9) ^ {16'(c), 16'(d)};
      return dw'({8'(c), 8'(d), 16'(seq), mix});
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic issue(input int c, input int d, input logic atom);
      req_dest[c] = d;
      req_atom[c] = atom;
   endtask

   // One falling edge with last cycle's data first and then the new requests
   task automatic step();
      int p;
      @(negedge rclk);
      for (int c = 0; c < nc; c++) begin
         spc_data_pa[c] = pend_data[c];
         pend_data[c]   = '0;
         spc_req_pq[c]  = '0;
         spc_atom_pq[c] = 1'b0;
         if (req_dest[c] >= 0) begin
            p = c * nd + req_dest[c];
            pend_data[c] = ref_data(c, req_dest[c], seq_no[p]);
            seq_no[p]++;
            spc_req_pq[c][req_dest[c]] = 1'b1;
            spc_atom_pq[c] = req_atom[c];
            exp_q[p].push_back({req_atom[c], pend_data[c]});
            credit[p]++;
            sent_cnt[c]++;
            sent_total++;
         end
         req_dest[c] = -1;
         req_atom[c] = 1'b0;
      end
   endtask

   // Keep stepping until every packet has its grant
   task automatic drain();
      int busy;
      busy = 1;
      while (busy != 0) begin
         step();
         busy = 0;
         for (int p = 0; p < nc * nd; p++) begin
            busy += credit[p];
         end
      end
   endtask

   task automatic apply_reset();
      @(negedge rclk);
      rst_n = 1'b0;
      repeat (3) @(negedge rclk);
      rst_n = 1'b1;
   endtask

   task automatic clear_log();
      log_src.delete();
      log_cyc.delete();
      log_atom.delete();
   endtask

   task automatic expect_true(input logic ok, input string what);
      assert (ok) else begin
         err_cnt++;
         $display("Check failed at %0t: %s", $time, what);
      end
   endtask

   task automatic check_value(input int got, input int exp, input string name);
      assert (got == exp) else begin
         err_cnt++;
         $display("FAIL %0t %s exp %0d got %0d", $time, name, exp, got);
      end
   endtask

   initial begin
      int   d;
      int   p;
      int   t0;
      logic atom;
      rst_n         = 1'b0;
      spc_req_pq    = '0;
      spc_atom_pq   = '0;
      spc_data_pa   = '0;
      dest_stall_pq = '0;
      rng_state     = 32'hd8eb_5ba4;
      credit        = '{default: 0};
      seq_no        = '{default: 0};
      sent_cnt      = '{default: 0};
      grant_cnt     = '{default: 0};
      req_dest      = '{default: -1};
      req_atom      = '{default: 1'b0};
      pend_data     = '{default: '0};
      second_dest   = '{default: -1};
      apply_reset();

      // Lone packet comes out two cycles after its data cycle
      issue(1, 1, 1'b0);
      step();
      t0 = cyc;
      drain();
      expect_true(log_src.size() == 1, "lone packet not delivered exactly once");
      check_value(log_cyc[0], t0 + 3, "dest_data_rdy_px[1] cycle");

      // All cores at bank 0 after reset while the pointer starts at core 0
      apply_reset();
      clear_log();
      for (int c = 0; c < nc; c++) begin
         issue(c, 0, 1'b0);
      end
      step();
      drain();
      expect_true(log_src.size() == nc, "round-robin burst lost packets");
      for (int i = 0; i < log_src.size(); i++) begin
         check_value(log_src[i], i, "dest_src_px[0]");
         check_value(log_cyc[i], log_cyc[0] + i, "dest_data_rdy_px[0] cycle");
      end

      // Fill every pair to bank 1 while it stalls
      clear_log();
      dest_stall_pq[1] = 1'b1;
      for (int n = 0; n < depth; n++) begin
         for (int c = 0; c < nc; c++) begin
            issue(c, 1, 1'b0);
         end
         step();
      end
      repeat (8) step();
      expect_true(log_src.size() == 0, "packet delivered to a stalled bank");
      dest_stall_pq[1] = 1'b0;
      drain();
      expect_true(log_src.size() == nc * depth, "packets lost behind a stall");

      // Atomic pair from core 2 with contenders one cycle later and a stall in the lock
      clear_log();
      issue(2, 0, 1'b1);
      step();
      for (int c = 0; c < nc; c++) begin
         issue(c, 0, 1'b0);  // Core 2 sends its second half here
      end
      step();
      step();
      step();
      dest_stall_pq[0] = 1'b1;  // Lock cycle while the first half is out
      repeat (6) step();
      dest_stall_pq[0] = 1'b0;
      drain();
      expect_true(log_src.size() == nc + 1, "atomic test lost packets");
      check_value(log_src[0], 2, "dest_src_px[0]");
      check_value(log_src[1], 2, "dest_src_px[0]");
      expect_true(log_atom[0] && !log_atom[1], "atomic flag on the wrong half");
      check_value(log_cyc[1], log_cyc[0] + 1, "dest_data_rdy_px[0] cycle");

      // Mixed traffic within the credit limit
      clear_log();
      for (int i = 0; i < rand_cycles; i++) begin
         for (int c = 0; c < nc; c++) begin
            rng_state = xorshift(rng_state);
            d    = int'(rng_state[15:8]) % nd;
            atom = (rng_state[19:16] == 4'h0);  // One in sixteen
            p    = c * nd + d;
            if (second_dest[c] >= 0) begin
               issue(c, second_dest[c], 1'b0);
               second_dest[c] = -1;
            end else if (rng_state[1:0] != 2'b00) begin
               if (atom && credit[p] <= depth - 2) begin
                  issue(c, d, 1'b1);
                  second_dest[c] = d;
               end else if (!atom && credit[p] < depth) begin
                  issue(c, d, 1'b0);
               end
            end
         end
         step();
         for (int b = 0; b < nd; b++) begin
            rng_state        = xorshift(rng_state);
            dest_stall_pq[b] = (rng_state[1:0] == 2'b00);
         end
      end
      for (int c = 0; c < nc; c++) begin
         if (second_dest[c] >= 0) issue(c, second_dest[c], 1'b0);
      end
      dest_stall_pq = '0;
      drain();

      for (int c = 0; c < nc; c++) begin
         assert (grant_cnt[c] == sent_cnt[c]) else begin
            err_cnt++;
            $display("FAIL %0t spc_grant_px[%0d] count exp %0d got %0d",
                     $time, c, sent_cnt[c], grant_cnt[c]);
         end
      end
      for (int q = 0; q < nc * nd; q++) begin
         expect_true(exp_q[q].size() == 0, "sent packets never delivered");
      end
      $display("Errors: %0d, packets sent: %0d", err_cnt, sent_total);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Scoreboard reads the registered outputs before they update
   always @(posedge rclk) begin
      int          src;
      int          ng;
      logic [dw:0] exp_ent;
      if (rst_n) begin
         for (int d = 0; d < nd; d++) begin
            ng = 0;
            for (int c = 0; c < nc; c++) begin
               if (spc_grant_px[c][d]) begin
                  ng++;
                  grant_cnt[c]++;
                  credit[c * nd + d]--;
               end
            end
            assert (ng == int'(dest_data_rdy_px[d])) else begin
               err_cnt++;
               $display("FAIL %0t spc_grant_px bank %0d exp %0d grants got %0d",
                        $time, d, dest_data_rdy_px[d], ng);
            end
            if (dest_data_rdy_px[d]) begin
               src = int'(dest_src_px[d]);
               log_src.push_back(src);
               log_cyc.push_back(cyc);
               log_atom.push_back(dest_atom_px[d]);
               // Grant goes back to the core that sent the packet
               assert (spc_grant_px[src][d]) else begin
                  err_cnt++;
                  $display("FAIL %0t spc_grant_px[%0d][%0d] exp 1 got 0", $time, src, d);
               end
               assert (exp_q[src * nd + d].size() > 0) else begin
                  err_cnt++;
                  $display("Bank %0d got a packet from core %0d that was never sent", d, src);
               end
               if (exp_q[src * nd + d].size() > 0) begin
                  exp_ent = exp_q[src * nd + d].pop_front();
                  assert (dest_data_px[d] == exp_ent[dw-1:0]) else begin
                     err_cnt++;
                     $display("FAIL %0t dest_data_px[%0d] exp %h got %h",
                              $time, d, exp_ent[dw-1:0], dest_data_px[d]);
                  end
                  assert (dest_atom_px[d] == exp_ent[dw]) else begin
                     err_cnt++;
                     $display("FAIL %0t dest_atom_px[%0d] exp %b got %b",
                              $time, d, exp_ent[dw], dest_atom_px[d]);
                  end
               end
            end
         end
      end
      cyc++;
   end

   // Limit grows with the traffic sent
   initial begin
      int wd_cyc;
      wd_cyc = 0;
      while (wd_cyc <= 10 * sent_total + 200) begin
         @(posedge rclk);
         wd_cyc++;
      end
      $display("Timeout after %0d cycles, %0d packets sent, run stopped", wd_cyc, sent_total);
      $display("Errors: %0d", err_cnt);
      $display("Finished with errors");
      $finish;
   end

endmodule

//--- compile.f
source/ccx_pkg.sv
source/pcx_ingress.sv
source/pcx_src_queue.sv
source/pcx_dest_arb.sv
source/pcx_xbar.sv
dv/pcx_xbar_props.sv
dv/pcx_xbar_tb.sv

//--- Makefile
# Verilator build and run of the PCX crossbar testbench
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= pcx_xbar_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, run did not complete"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
